/* common/can_rx_pkg.sv */
package can_rx_pkg;

    // bit timing
    localparam int CLK_FREQ       = 50_000_000;
    localparam int BIT_RATE       = 5_000_000;
    localparam int QUANTS_PER_BIT = CLK_FREQ / BIT_RATE;
    localparam int SAMPLE_POINT   = QUANTS_PER_BIT / 2;
    localparam int QCNT_W         = $clog2(QUANTS_PER_BIT);

    // field lengths in bits
    localparam int MSG_TYPE_LEN  = 1;
    localparam int ADDR_LEN      = 6;
    localparam int ADDR_HI_LEN   = 4;
    localparam int HANDSHAKE_LEN = 2;
    localparam int ATTR_LEN      = 2;
    localparam int EXPAND_LEN    = 4;
    localparam int SIGN_LEN      = 8;
    localparam int RESERVED_LEN  = 2;
    localparam int DLC_LEN       = 4;
    localparam int DATA_LEN      = 64;
    localparam int CRC_LEN       = 15;
    localparam int EOF_LEN       = 7;
    localparam int STUFF_RUN     = 5;

    localparam logic [CRC_LEN-1:0] CRC_POLY = 15'h4599;

    localparam int BIT_CNT_W = $clog2(DATA_LEN + 1);

    typedef struct packed {
        logic stb;
        logic value;
    } can_bit_t;

    // stuffing and crc windows are ranges of this enum
    typedef enum logic [4:0] {
        IDLE,
        MSG_TYPE,
        ADDR_LOCAL,
        ADDR_REMOTE_HI,
        SRR,
        IDE,
        ADDR_REMOTE_LO,
        HANDSHAKE,
        ATTR,
        EXPAND,
        SIGN,
        RTR,
        RESERVED,
        DLC,
        DATA,
        CRC,
        CRC_DELIM,
        ACK_SLOT,
        ACK_DELIM,
        EOF
    } can_rx_state_e;

    typedef struct packed {
        logic [MSG_TYPE_LEN-1:0]  msg_type;
        logic [ADDR_LEN-1:0]      addr_local;
        logic [ADDR_LEN-1:0]      addr_remote;
        logic [HANDSHAKE_LEN-1:0] handshake;
        logic [ATTR_LEN-1:0]      attr;
        logic [EXPAND_LEN-1:0]    expand;
        logic [SIGN_LEN-1:0]      sign;
        logic                     rtr;
        logic [DLC_LEN-1:0]       dlc;
        logic [DATA_LEN-1:0]      data;
        logic                     crc_ok;
    } can_frame_t;

endpackage

/* hw/can_bit_timing.sv */
`timescale 1ns/1ps

module can_bit_timing
    import can_rx_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     rx_i,
    output can_bit_t samp_o
);

    logic [QCNT_W-1:0] qcnt_q;
    logic              rx_q;
    logic              rx_edge;

    assign rx_edge = (rx_i != rx_q);

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            rx_q <= 1'b1;
        end else begin
            rx_q <= rx_i;
        end
    end

    // quanta counter restarted by any edge on the line
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            qcnt_q <= '0;
        end else if (rx_edge) begin
            qcnt_q <= '0;
        end else if (qcnt_q == QCNT_W'(QUANTS_PER_BIT - 1)) begin
            qcnt_q <= '0;
        end else begin
            qcnt_q <= qcnt_q + 1'b1;
        end
    end

    // sample in the middle of the bit
    assign samp_o.stb   = (qcnt_q == QCNT_W'(SAMPLE_POINT));
    assign samp_o.value = rx_i;

endmodule

/* hw/can_destuff.sv */
`timescale 1ns/1ps

module can_destuff
    import can_rx_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  can_bit_t samp_i,
    input  logic     stuff_en_i,
    output can_bit_t bit_o
);

    localparam int RUN_W = $clog2(STUFF_RUN + 1);

    logic [RUN_W-1:0] run_q;
    logic             last_q;
    logic             drop;

    // sample right after a full run is a stuff bit
    assign drop = stuff_en_i && (run_q == RUN_W'(STUFF_RUN));

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            run_q  <= '0;
            last_q <= 1'b1;
        end else if (samp_i.stb) begin
            last_q <= samp_i.value;
            if (!stuff_en_i || drop || samp_i.value != last_q) begin
                run_q <= RUN_W'(1);
            end else begin
                run_q <= run_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            bit_o <= '0;
        end else begin
            bit_o.stb   <= samp_i.stb && !drop;
            bit_o.value <= samp_i.value;
        end
    end

endmodule

/* hw/can_crc15.sv */
`timescale 1ns/1ps

module can_crc15
    import can_rx_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_i,
    input  can_bit_t           bit_i,
    input  logic               en_i,
    input  logic               clr_i,
    output logic [CRC_LEN-1:0] crc_o
);

    logic fb;

    assign fb = bit_i.value ^ crc_o[CRC_LEN-1];

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            crc_o <= '0;
        end else if (clr_i) begin
            crc_o <= '0;
        end else if (en_i && bit_i.stb) begin
            crc_o <= {crc_o[CRC_LEN-2:0], 1'b0} ^ (fb ? CRC_POLY : '0);
        end
    end

endmodule

/* hw/can_rx_fsm.sv */
`timescale 1ns/1ps

module can_rx_fsm
    import can_rx_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                init_i,
    input  logic [ADDR_LEN-1:0] local_addr_i,
    input  can_bit_t            bit_i,
    input  logic [CRC_LEN-1:0]  crc_i,
    output logic                stuff_en_o,
    output logic                crc_en_o,
    output logic                crc_clr_o,
    output logic                tx_o,
    output logic                rx_busy_o,
    output logic                frame_valid_o,
    output can_frame_t          frame_o
);

    can_rx_state_e         state_q;
    logic [BIT_CNT_W-1:0]  bit_cnt_q;
    logic [ADDR_LEN-1:0]   local_addr_q;
    logic                  ack_q;
    can_frame_t            frame_q;
    logic [CRC_LEN-1:0]    rx_crc_q;
    logic                  last_bit;
    logic                  sof;
    logic                  addr_match;

    // single-bit fields fall to the default
    function automatic logic [BIT_CNT_W-1:0] field_len(input can_rx_state_e st);
        case (st)
            MSG_TYPE:       return BIT_CNT_W'(MSG_TYPE_LEN);
            ADDR_LOCAL:     return BIT_CNT_W'(ADDR_LEN);
            ADDR_REMOTE_HI: return BIT_CNT_W'(ADDR_HI_LEN);
            ADDR_REMOTE_LO: return BIT_CNT_W'(ADDR_LEN - ADDR_HI_LEN);
            HANDSHAKE:      return BIT_CNT_W'(HANDSHAKE_LEN);
            ATTR:           return BIT_CNT_W'(ATTR_LEN);
            EXPAND:         return BIT_CNT_W'(EXPAND_LEN);
            SIGN:           return BIT_CNT_W'(SIGN_LEN);
            RESERVED:       return BIT_CNT_W'(RESERVED_LEN);
            DLC:            return BIT_CNT_W'(DLC_LEN);
            DATA:           return BIT_CNT_W'(DATA_LEN);
            CRC:            return BIT_CNT_W'(CRC_LEN);
            EOF:            return BIT_CNT_W'(EOF_LEN);
            default:        return BIT_CNT_W'(1);
        endcase
    endfunction

    assign last_bit   = (bit_cnt_q == field_len(state_q) - 1'b1);
    assign sof        = (state_q == IDLE) && bit_i.stb && !bit_i.value;
    assign addr_match = ({frame_q.addr_remote[ADDR_LEN-2:0], bit_i.value} == local_addr_q);

    assign stuff_en_o = (state_q >= MSG_TYPE) && (state_q <= CRC);
    assign crc_en_o   = (state_q >= MSG_TYPE) && (state_q <= DATA);
    assign crc_clr_o  = sof;
    // dominant ack only for frames addressed to us
    assign tx_o       = !((state_q == ACK_SLOT) && ack_q);
    assign frame_o    = frame_q;

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            local_addr_q <= '0;
        end else if (init_i) begin
            local_addr_q <= local_addr_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            state_q       <= IDLE;
            bit_cnt_q     <= '0;
            ack_q         <= 1'b0;
            rx_busy_o     <= 1'b0;
            frame_valid_o <= 1'b0;
        end else begin
            frame_valid_o <= 1'b0;
            if (sof) begin
                state_q   <= MSG_TYPE;
                bit_cnt_q <= '0;
                ack_q     <= 1'b0;
                rx_busy_o <= 1'b1;
            end else if (bit_i.stb && state_q != IDLE) begin
                if (last_bit) begin
                    bit_cnt_q <= '0;
                    if (state_q == EOF) begin
                        state_q       <= IDLE;
                        rx_busy_o     <= 1'b0;
                        frame_valid_o <= 1'b1;
                    end else begin
                        state_q <= can_rx_state_e'(state_q + 1'b1);
                    end
                    if (state_q == ADDR_REMOTE_LO) begin
                        ack_q <= addr_match;
                    end
                end else begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end
            end
        end
    end

    // fields shift in msb first
    always_ff @(posedge clk_i) begin
        if (bit_i.stb) begin
            case (state_q)
                MSG_TYPE: begin
                    frame_q.msg_type <= bit_i.value;
                end
                ADDR_LOCAL: begin
                    frame_q.addr_local <= {frame_q.addr_local[ADDR_LEN-2:0], bit_i.value};
                end
                // remote address is split around srr and ide
                ADDR_REMOTE_HI, ADDR_REMOTE_LO: begin
                    frame_q.addr_remote <= {frame_q.addr_remote[ADDR_LEN-2:0], bit_i.value};
                end
                HANDSHAKE: begin
                    frame_q.handshake <= {frame_q.handshake[HANDSHAKE_LEN-2:0], bit_i.value};
                end
                ATTR: begin
                    frame_q.attr <= {frame_q.attr[ATTR_LEN-2:0], bit_i.value};
                end
                EXPAND: begin
                    frame_q.expand <= {frame_q.expand[EXPAND_LEN-2:0], bit_i.value};
                end
                SIGN: begin
                    frame_q.sign <= {frame_q.sign[SIGN_LEN-2:0], bit_i.value};
                end
                RTR: begin
                    frame_q.rtr <= bit_i.value;
                end
                DLC: begin
                    frame_q.dlc <= {frame_q.dlc[DLC_LEN-2:0], bit_i.value};
                end
                DATA: begin
                    frame_q.data <= {frame_q.data[DATA_LEN-2:0], bit_i.value};
                end
                CRC: begin
                    rx_crc_q <= {rx_crc_q[CRC_LEN-2:0], bit_i.value};
                    if (last_bit) begin
                        frame_q.crc_ok <= ({rx_crc_q[CRC_LEN-2:0], bit_i.value} == crc_i);
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* hw/can_rx.sv */
`timescale 1ns/1ps

module can_rx
    import can_rx_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                init_i,
    input  logic [ADDR_LEN-1:0] local_addr_i,
    input  logic                rx_i,
    output logic                tx_o,
    output logic                rx_busy_o,
    output logic                frame_valid_o,
    output can_frame_t          frame_o
);

    can_bit_t           samp;
    can_bit_t           dbit;
    logic               stuff_en;
    logic               crc_en;
    logic               crc_clr;
    logic [CRC_LEN-1:0] crc;

    can_bit_timing u_bit_timing (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .rx_i   (rx_i),
        .samp_o (samp)
    );

    can_destuff u_destuff (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .samp_i     (samp),
        .stuff_en_i (stuff_en),
        .bit_o      (dbit)
    );

    can_crc15 u_crc15 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .bit_i (dbit),
        .en_i  (crc_en),
        .clr_i (crc_clr),
        .crc_o (crc)
    );

    can_rx_fsm u_rx_fsm (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .init_i        (init_i),
        .local_addr_i  (local_addr_i),
        .bit_i         (dbit),
        .crc_i         (crc),
        .stuff_en_o    (stuff_en),
        .crc_en_o      (crc_en),
        .crc_clr_o     (crc_clr),
        .tx_o          (tx_o),
        .rx_busy_o     (rx_busy_o),
        .frame_valid_o (frame_valid_o),
        .frame_o       (frame_o)
    );

endmodule

/* bench/can_rx_chk.sv */
`timescale 1ns/1ps

module can_rx_chk (
    input logic clk_i,
    input logic rst_i,
    input logic tx_i,
    input logic rx_busy_i,
    input logic frame_valid_i
);

    // single-cycle strobe
    valid_strobe_a: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        frame_valid_i |=> !frame_valid_i
    ) else $error("frame_valid_o high for two cycles");

    // dominant ack only inside a frame
    tx_in_frame_a: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        !tx_i |-> rx_busy_i
    ) else $error("tx_o low while rx_busy_o is low");

    busy_drop_a: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        frame_valid_i |=> !rx_busy_i
    ) else $error("rx_busy_o still high after frame_valid_o");

endmodule

/* bench/tb_can_rx.sv */
`timescale 1ns/1ps

module tb_can_rx
    import can_rx_pkg::*;
();

    localparam int HALF_PERIOD  = 10;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 4;
    // about 10 frames of 180 bits at 11 cycles each with margin
    localparam int MAX_CYCLES   = 30_000;
    localparam int VALID_WAIT   = 20 * QUANTS_PER_BIT;
    localparam int IDLE_BITS    = 5;

    logic                clk_i = 1'b0;
    logic                rst_i;
    logic                init_i;
    logic [ADDR_LEN-1:0] local_addr_i;
    logic                rx_i;
    logic                tx_o;
    logic                rx_busy_o;
    logic                frame_valid_o;
    can_frame_t          frame_o;

    logic        pl_q[$];
    logic        wire_q[$];
    int          ack_idx;
    logic        ack_tx;
    logic        ack_busy;
    int          valid_cnt  = 0;
    int          tx_low_cnt = 0;
    int          cycle_cnt  = 0;
    can_frame_t  got_frame;
    int unsigned seed_val;

    can_rx u_can_rx (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .init_i        (init_i),
        .local_addr_i  (local_addr_i),
        .rx_i          (rx_i),
        .tx_o          (tx_o),
        .rx_busy_o     (rx_busy_o),
        .frame_valid_o (frame_valid_o),
        .frame_o       (frame_o)
    );

    bind can_rx can_rx_chk u_can_rx_chk (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .tx_i          (tx_o),
        .rx_busy_i     (rx_busy_o),
        .frame_valid_i (frame_valid_o)
    );

    always #HALF_PERIOD clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (frame_valid_o) begin
            valid_cnt++;
            got_frame = frame_o;
        end
        if (!tx_o) begin
            tx_low_cnt++;
        end
    end

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic next_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic check_frame(input string name, input can_frame_t exp, input can_frame_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    function automatic can_frame_t rand_frame();
        can_frame_t f;
        f.msg_type    = MSG_TYPE_LEN'($urandom());
        f.addr_local  = ADDR_LEN'($urandom());
        f.addr_remote = ADDR_LEN'($urandom());
        f.handshake   = HANDSHAKE_LEN'($urandom());
        f.attr        = ATTR_LEN'($urandom());
        f.expand      = EXPAND_LEN'($urandom());
        f.sign        = SIGN_LEN'($urandom());
        f.rtr         = 1'($urandom());
        f.dlc         = DLC_LEN'($urandom());
        f.data        = {$urandom(), $urandom()};
        f.crc_ok      = 1'b1;
        return f;
    endfunction

    // msb first
    task automatic push_field(input logic [63:0] v, input int len);
        logic [63:0] sh;
        sh = v << (64 - len);
        repeat (len) begin
            pl_q.push_back(sh[63]);
            sh = sh << 1;
        end
    endtask

    task automatic build_frame(input can_frame_t f, input logic bad_crc);
        logic [CRC_LEN-1:0] crc;
        logic               fb;
        logic               last;
        int                 run;
        int unsigned        pos;
        pl_q.delete();
        wire_q.delete();
        push_field(64'(f.msg_type), MSG_TYPE_LEN);
        push_field(64'(f.addr_local), ADDR_LEN);
        push_field(64'(f.addr_remote[ADDR_LEN-1:ADDR_LEN-ADDR_HI_LEN]), ADDR_HI_LEN);
        // srr and ide are both recessive
        push_field(64'd3, 2);
        push_field(64'(f.addr_remote[ADDR_LEN-ADDR_HI_LEN-1:0]), ADDR_LEN - ADDR_HI_LEN);
        push_field(64'(f.handshake), HANDSHAKE_LEN);
        push_field(64'(f.attr), ATTR_LEN);
        push_field(64'(f.expand), EXPAND_LEN);
        push_field(64'(f.sign), SIGN_LEN);
        push_field(64'(f.rtr), 1);
        push_field(64'd0, RESERVED_LEN);
        push_field(64'(f.dlc), DLC_LEN);
        push_field(f.data, DATA_LEN);
        crc = '0;
        foreach (pl_q[i]) begin
            fb  = pl_q[i] ^ crc[CRC_LEN-1];
            crc = {crc[CRC_LEN-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ CRC_POLY;
            end
        end
        if (bad_crc) begin
            pos = $urandom() % CRC_LEN;
            crc = crc ^ (CRC_LEN'(1) << pos);
        end
        push_field(64'(crc), CRC_LEN);
        pl_q.push_front(1'b0);
        // stuff bit goes in before the sixth equal bit
        last = 1'b1;
        run  = 0;
        foreach (pl_q[i]) begin
            if (run == STUFF_RUN) begin
                wire_q.push_back(!last);
                last = !last;
                run  = 1;
            end
            if (pl_q[i] == last) begin
                run++;
            end else begin
                last = pl_q[i];
                run  = 1;
            end
            wire_q.push_back(pl_q[i]);
        end
        wire_q.push_back(1'b1);
        ack_idx = wire_q.size();
        // ack slot, ack delimiter, eof and idle gap
        repeat (2 + EOF_LEN + IDLE_BITS) wire_q.push_back(1'b1);
    endtask

    task automatic drive_bits(input logic jitter);
        int          len;
        int          dev;
        int unsigned rnd;
        dev = 0;
        foreach (wire_q[i]) begin
            if (i > 0 && wire_q[i] != wire_q[i - 1]) begin
                dev = 0;
            end
            len = QUANTS_PER_BIT;
            if (jitter) begin
                rnd = $urandom();
                // drift between two edges stays within two cycles
                if (dev <= -2) begin
                    len = QUANTS_PER_BIT + 1;
                end else if (dev >= 2) begin
                    len = QUANTS_PER_BIT - 1;
                end else begin
                    len = rnd[0] ? QUANTS_PER_BIT + 1 : QUANTS_PER_BIT - 1;
                end
                dev += len - QUANTS_PER_BIT;
            end
            for (int j = 0; j < len; j++) begin
                @(posedge clk_i);
                #DRIVE_DELAY;
                rx_i = wire_q[i];
                if (i == ack_idx && j == QUANTS_PER_BIT / 2) begin
                    ack_tx   = tx_o;
                    ack_busy = rx_busy_o;
                end
            end
        end
    endtask

    task automatic wait_valid(input int target);
        int waited;
        waited = 0;
        while (valid_cnt < target && waited < VALID_WAIT) begin
            next_cycles(1);
            waited++;
        end
        if (valid_cnt < target) begin
            $display("no frame_valid_o pulse within %0d cycles after the frame", VALID_WAIT);
            stop_run();
        end
    endtask

    task automatic send_frame(input can_frame_t f, input logic bad_crc, input logic jitter);
        can_frame_t exp;
        int         start_cnt;
        exp        = f;
        exp.crc_ok = !bad_crc;
        start_cnt  = valid_cnt;
        ack_busy   = 1'b0;
        build_frame(f, bad_crc);
        drive_bits(jitter);
        wait_valid(start_cnt + 1);
        check_frame("frame_o", exp, got_frame);
        check_count("frame_valid_o pulses", start_cnt + 1, valid_cnt);
        // busy inside the frame, released once it is delivered
        check_bit("rx_busy_o", 1'b1, ack_busy);
        check_bit("rx_busy_o", 1'b0, rx_busy_o);
    endtask

    task automatic reset_and_idle();
        check_bit("rx_busy_o", 1'b0, rx_busy_o);
        check_bit("frame_valid_o", 1'b0, frame_valid_o);
        check_bit("tx_o", 1'b1, tx_o);
        next_cycles(50 * QUANTS_PER_BIT);
        check_count("frame_valid_o pulses", 0, valid_cnt);
        check_bit("rx_busy_o", 1'b0, rx_busy_o);
    endtask

    task automatic stuff_dense_rx();
        can_frame_t f;
        f        = '0;
        f.expand = '1;
        f.sign   = '1;
        f.dlc    = 4'h8;
        f.crc_ok = 1'b1;
        send_frame(f, 1'b0, 1'b0);
    endtask

    task automatic ack_by_address();
        can_frame_t          f;
        logic [ADDR_LEN-1:0] addr;
        int                  low_before;
        addr         = ADDR_LEN'($urandom());
        init_i       = 1'b1;
        local_addr_i = addr;
        next_cycles(1);
        init_i = 1'b0;
        f             = rand_frame();
        f.addr_remote = addr;
        ack_tx        = 1'b1;
        send_frame(f, 1'b0, 1'b0);
        check_bit("tx_o", 1'b0, ack_tx);
        // another address must not be acknowledged
        f             = rand_frame();
        f.addr_remote = addr ^ 6'h21;
        low_before    = tx_low_cnt;
        send_frame(f, 1'b0, 1'b0);
        check_bit("tx_o", 1'b1, ack_tx);
        check_count("tx_o low cycles", low_before, tx_low_cnt);
    endtask

    initial begin
        rst_i        = 1'b0;
        init_i       = 1'b0;
        local_addr_i = '0;
        rx_i         = 1'b1;
        ack_tx       = 1'b1;
        ack_busy     = 1'b0;
        seed_val     = $urandom(32'hd2185b5e);
        next_cycles(RESET_CYCLES);
        rst_i = 1'b1;
        reset_and_idle();
        send_frame(rand_frame(), 1'b0, 1'b0);
        stuff_dense_rx();
        send_frame(rand_frame(), 1'b1, 1'b0);
        ack_by_address();
        repeat (3) send_frame(rand_frame(), 1'b0, 1'b1);
        $display("All tests passed");
        $finish;
    end

endmodule

/* sources.f */
common/can_rx_pkg.sv
hw/can_bit_timing.sv
hw/can_destuff.sv
hw/can_crc15.sv
hw/can_rx_fsm.sv
hw/can_rx.sv
bench/can_rx_chk.sv
bench/tb_can_rx.sv

/* run.sh */
#!/bin/sh
# build and run the can_rx testbench with Verilator, the log decides the result
rm -f sim.log
verilator --binary --timing --assert --top-module tb_can_rx -f sources.f -Mdir obj_dir \
    && ./obj_dir/Vtb_can_rx > sim.log 2>&1
cat sim.log 2>/dev/null
# a run that ended without the pass line counts as failed
grep -q "All tests passed" sim.log 2>/dev/null || echo "Some tests failed" >> sim.log
grep -q "Some tests failed" sim.log && echo "FAIL" && exit 1
echo "PASS"
